/* src/conv_pkg.sv */
package conv_pkg;

    // frame geometry
    localparam int ROWS  = 7;
    localparam int COLS  = 7;
    localparam int KSIZE = 5;
    // padding depth and lag of the window centre
    localparam int HALF  = KSIZE / 2;

    // data widths
    localparam int PIX_W  = 8;
    localparam int COEF_W = 8;
    // 25 signed products need 21 bits
    localparam int RES_W  = 21;
    localparam int POS_W  = 3;

    // output link credits
    localparam int MAX_CREDITS = 4;
    localparam int CRED_W      = 3;

    // zero beats pushed after the last pixel to drain the window
    localparam int FLUSH_BEATS = HALF * COLS + HALF;

    typedef struct packed {
        logic [RES_W-1:0] data;
        logic [POS_W-1:0] row;
        logic [POS_W-1:0] col;
        logic             last;
    } res_t;

    // position of a window centre carried next to the window data
    typedef struct packed {
        logic [POS_W-1:0] row;
        logic [POS_W-1:0] col;
        logic             last;
    } win_pos_t;

endpackage

/* src/conv_frame_ctrl.sv */
`timescale 1ns/1ps

module conv_frame_ctrl import conv_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_pix_valid,
    input  logic i_res_credit,
    input  logic i_win_due,
    output logic o_pix_ready,
    output logic o_adv,
    output logic o_flush,
    output logic o_start
);

    localparam int NPIX = ROWS * COLS;

    logic [$clog2(NPIX)-1:0]        pix_cnt;
    logic [$clog2(FLUSH_BEATS)-1:0] flush_cnt;
    logic                           flushing;
    logic                           start_q;
    logic [CRED_W-1:0]              credits;
    logic                           credit_ok;
    logic                           spend;

    // a beat that yields a window needs a free result slot downstream
    assign credit_ok = !i_win_due || (credits != '0);

    assign o_pix_ready = !flushing && !start_q && credit_ok;
    assign o_adv       = flushing ? credit_ok : (i_pix_valid && o_pix_ready);
    assign o_flush     = flushing;
    assign o_start     = start_q;

    assign spend = o_adv && i_win_due;

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_cnt   <= '0;
            flush_cnt <= '0;
            flushing  <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (o_adv) begin
                if (flushing) begin
                    if (flush_cnt == FLUSH_BEATS - 1) begin
                        flush_cnt <= '0;
                        flushing  <= 1'b0;
                        // one idle cycle to restart the window counters
                        start_q   <= 1'b1;
                    end else begin
                        flush_cnt <= flush_cnt + 1'b1;
                    end
                end else if (pix_cnt == NPIX - 1) begin
                    pix_cnt  <= '0;
                    flushing <= 1'b1;
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end
        end
    end

    // credits are spent per window and returned by the consumer
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(MAX_CREDITS);
        end else begin
            credits <= credits - CRED_W'(spend) + CRED_W'(i_res_credit);
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        credits <= CRED_W'(MAX_CREDITS))
        else $error("credit counter above MAX_CREDITS");

    // a returned credit must match a result that is still outstanding
    assert property (@(posedge clk) disable iff (rst)
        i_res_credit |-> credits < CRED_W'(MAX_CREDITS))
        else $error("credit returned with no result outstanding");

    assert property (@(posedge clk) disable iff (rst)
        spend |-> credits != '0)
        else $error("credit spent with the counter at zero");

endmodule

/* src/conv_line_buffer.sv */
`timescale 1ns/1ps

module conv_line_buffer import conv_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_adv,
    input  logic [PIX_W-1:0]               i_pix,
    output logic [0:KSIZE-1][PIX_W-1:0]    o_col
);

    // four previous rows with row 0 the most recent
    logic [PIX_W-1:0] rows_q [KSIZE-1][COLS];
    logic [POS_W-1:0] ptr;

    // every beat writes one column, so an entry is always COLS beats old
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (i_adv) begin
            if (ptr == POS_W'(COLS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_adv) begin
            for (int k = KSIZE - 2; k > 0; k--) begin
                rows_q[k][ptr] <= rows_q[k-1][ptr];
            end
            rows_q[0][ptr] <= i_pix;
        end
    end

    // oldest row first and the incoming pixel last
    always_comb begin
        for (int k = 0; k < KSIZE - 1; k++) begin
            o_col[k] = rows_q[KSIZE-2-k][ptr];
        end
        o_col[KSIZE-1] = i_pix;
    end

endmodule

/* src/conv_window_5x5.sv */
`timescale 1ns/1ps

module conv_window_5x5 import conv_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_adv,
    input  logic                                i_start,
    input  logic [0:KSIZE-1][PIX_W-1:0]         i_col,
    output logic                                o_win_due,
    output logic                                o_win_valid,
    output logic [0:KSIZE*KSIZE-1][PIX_W-1:0]   o_win,
    output win_pos_t                            o_pos
);

    // column KSIZE-1 of the shift array holds the newest pixels
    logic [PIX_W-1:0] sr  [KSIZE][KSIZE];
    logic [PIX_W-1:0] nxt [KSIZE][KSIZE];

    logic [$clog2(FLUSH_BEATS)-1:0] warm_cnt;
    logic [POS_W-1:0]               row_cnt;
    logic [POS_W-1:0]               col_cnt;
    logic                           last_centre;
    logic [KSIZE-1:0]               row_ok;
    logic [KSIZE-1:0]               col_ok;

    assign last_centre = (row_cnt == POS_W'(ROWS - 1)) && (col_cnt == POS_W'(COLS - 1));

    always_comb begin
        for (int r = 0; r < KSIZE; r++) begin
            for (int c = 0; c < KSIZE - 1; c++) begin
                nxt[r][c] = sr[r][c+1];
            end
            nxt[r][KSIZE-1] = i_col[r];
        end
    end

    // taps whose offset from the centre leaves the frame read as zero
    always_comb begin
        int rr;
        int cc;
        for (int k = 0; k < KSIZE; k++) begin
            rr = int'(row_cnt) + k - HALF;
            cc = int'(col_cnt) + k - HALF;
            row_ok[k] = (rr >= 0) && (rr < ROWS);
            col_ok[k] = (cc >= 0) && (cc < COLS);
        end
    end

    always_ff @(posedge clk) begin
        if (i_adv) begin
            for (int r = 0; r < KSIZE; r++) begin
                for (int c = 0; c < KSIZE; c++) begin
                    sr[r][c] <= nxt[r][c];
                    o_win[r*KSIZE+c] <= (row_ok[r] && col_ok[c]) ? nxt[r][c] : '0;
                end
            end
            o_pos.row  <= row_cnt;
            o_pos.col  <= col_cnt;
            o_pos.last <= last_centre;
        end
    end

    // o_win_due tells the controller that the next beat yields a window
    always_ff @(posedge clk) begin
        if (rst) begin
            warm_cnt    <= '0;
            row_cnt     <= '0;
            col_cnt     <= '0;
            o_win_due   <= 1'b0;
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= i_adv && o_win_due;
            if (i_start) begin
                warm_cnt  <= '0;
                row_cnt   <= '0;
                col_cnt   <= '0;
                o_win_due <= 1'b0;
            end else if (i_adv) begin
                if (o_win_due) begin
                    if (col_cnt == POS_W'(COLS - 1)) begin
                        col_cnt <= '0;
                        if (row_cnt == POS_W'(ROWS - 1)) begin
                            row_cnt   <= '0;
                            o_win_due <= 1'b0;
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end else if (warm_cnt == FLUSH_BEATS - 1) begin
                    // centre reaches pixel 0 on the next beat
                    warm_cnt  <= '0;
                    o_win_due <= 1'b1;
                end else begin
                    warm_cnt <= warm_cnt + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        o_win_valid |-> (o_pos.row < POS_W'(ROWS)) && (o_pos.col < POS_W'(COLS)))
        else $error("window centre outside the frame");

endmodule

/* src/conv_mac_5x5.sv */
`timescale 1ns/1ps

module conv_mac_5x5 import conv_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_coef_we,
    input  logic [4:0]                          i_coef_addr,
    input  logic [COEF_W-1:0]                   i_coef_data,
    input  logic                                i_win_valid,
    input  logic [0:KSIZE*KSIZE-1][PIX_W-1:0]   i_win,
    input  win_pos_t                            i_pos,
    output logic                                o_res_valid,
    output res_t                                o_res
);

    logic signed [COEF_W-1:0] coef [KSIZE*KSIZE];

    logic signed [RES_W-1:0] row_sum [KSIZE];
    logic signed [RES_W-1:0] s1_sum  [KSIZE];
    logic signed [RES_W-1:0] total;
    logic                    s1_valid;
    win_pos_t                s1_pos;

    // kernel store in raster order
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < KSIZE * KSIZE; k++) begin
                coef[k] <= '0;
            end
        end else if (i_coef_we && (i_coef_addr < 5'(KSIZE * KSIZE))) begin
            coef[i_coef_addr] <= i_coef_data;
        end
    end

    // stage 1 products with a zero sign bit on the unsigned pixels
    always_comb begin
        logic signed [PIX_W:0]        px;
        logic signed [PIX_W+COEF_W:0] prod;
        logic signed [RES_W-1:0]      acc;
        for (int r = 0; r < KSIZE; r++) begin
            acc = '0;
            for (int c = 0; c < KSIZE; c++) begin
                px   = $signed({1'b0, i_win[r*KSIZE+c]});
                prod = px * coef[r*KSIZE+c];
                acc  = acc + RES_W'(prod);
            end
            row_sum[r] = acc;
        end
    end

    always_comb begin
        total = '0;
        for (int r = 0; r < KSIZE; r++) begin
            total = total + s1_sum[r];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            o_res_valid <= 1'b0;
        end else begin
            s1_valid    <= i_win_valid;
            o_res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_sum     <= row_sum;
        s1_pos     <= i_pos;
        o_res.data <= total;
        o_res.row  <= s1_pos.row;
        o_res.col  <= s1_pos.col;
        o_res.last <= s1_pos.last;
    end

    // kernel only changes while no window is in flight
    assert property (@(posedge clk) disable iff (rst)
        i_coef_we |-> !i_win_valid && !s1_valid)
        else $error("coefficient written while a window is in flight");

endmodule

/* src/conv_engine_top.sv */
`timescale 1ns/1ps

module conv_engine_top import conv_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_pix_valid,
    input  logic [PIX_W-1:0]  i_pix,
    output logic              o_pix_ready,
    input  logic              i_coef_we,
    input  logic [4:0]        i_coef_addr,
    input  logic [COEF_W-1:0] i_coef_data,
    output logic              o_res_valid,
    output res_t              o_res,
    input  logic              i_res_credit
);

    logic                              adv;
    logic                              flush;
    logic                              start;
    logic                              win_due;
    logic                              win_valid;
    logic [PIX_W-1:0]                  lb_pix;
    logic [0:KSIZE-1][PIX_W-1:0]       lb_col;
    logic [0:KSIZE*KSIZE-1][PIX_W-1:0] win;
    win_pos_t                          pos;

    // flush beats push zeros behind the last pixel
    assign lb_pix = flush ? '0 : i_pix;

    conv_frame_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_pix_valid  (i_pix_valid),
        .i_res_credit (i_res_credit),
        .i_win_due    (win_due),
        .o_pix_ready  (o_pix_ready),
        .o_adv        (adv),
        .o_flush      (flush),
        .o_start      (start)
    );

    conv_line_buffer u_lbuf (
        .clk   (clk),
        .rst   (rst),
        .i_adv (adv),
        .i_pix (lb_pix),
        .o_col (lb_col)
    );

    conv_window_5x5 u_win (
        .clk         (clk),
        .rst         (rst),
        .i_adv       (adv),
        .i_start     (start),
        .i_col       (lb_col),
        .o_win_due   (win_due),
        .o_win_valid (win_valid),
        .o_win       (win),
        .o_pos       (pos)
    );

    conv_mac_5x5 u_mac (
        .clk         (clk),
        .rst         (rst),
        .i_coef_we   (i_coef_we),
        .i_coef_addr (i_coef_addr),
        .i_coef_data (i_coef_data),
        .i_win_valid (win_valid),
        .i_win       (win),
        .i_pos       (pos),
        .o_res_valid (o_res_valid),
        .o_res       (o_res)
    );

endmodule

/* sim/conv_tb.sv */
`timescale 1ns/1ps

module conv_tb import conv_pkg::*; ();

    localparam int NPIX        = ROWS * COLS;
    localparam int PIX_LIMIT   = 300;
    localparam int DRAIN_LIMIT = 3000;

    logic              clk;
    logic              rst;
    logic              i_pix_valid;
    logic [PIX_W-1:0]  i_pix;
    logic              o_pix_ready;
    logic              i_coef_we;
    logic [4:0]        i_coef_addr;
    logic [COEF_W-1:0] i_coef_data;
    logic              o_res_valid;
    res_t              o_res;
    logic              i_res_credit;

    int   img  [2][NPIX];
    int   kern [KSIZE*KSIZE];
    res_t exp_q [$];
    res_t exp_head;
    logic exp_avail    = 1'b0;
    logic hold_credits = 1'b0;
    int   unacked      = 0;
    int   got          = 0;
    int   checks       = 0;
    int   errors       = 0;
    int   base         = 0;

    conv_engine_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_pix_valid  (i_pix_valid),
        .i_pix        (i_pix),
        .o_pix_ready  (o_pix_ready),
        .i_coef_we    (i_coef_we),
        .i_coef_addr  (i_coef_addr),
        .i_coef_data  (i_coef_data),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res),
        .i_res_credit (i_res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // consumer takes the expected head for each result and returns credits
    always @(negedge clk) begin
        if (!rst && o_res_valid) begin
            got++;
            unacked++;
            exp_avail = (exp_q.size() > 0);
            if (exp_avail) begin
                exp_head = exp_q.pop_front();
                checks++;
            end
        end
        if (!rst && !hold_credits && unacked > 0) begin
            i_res_credit = 1'b1;
            unacked--;
        end else begin
            i_res_credit = 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) o_res_valid |-> exp_avail)
        else begin
            errors++;
            $display("a result arrived when none was expected");
        end
    assert property (@(posedge clk) disable iff (rst)
        o_res_valid && exp_avail |-> o_res.data == exp_head.data)
        else begin
            errors++;
            $display("Error: o_res.data expected %h got %h", exp_head.data, $sampled(o_res.data));
        end
    assert property (@(posedge clk) disable iff (rst)
        o_res_valid && exp_avail |-> o_res.row == exp_head.row)
        else begin
            errors++;
            $display("Error: o_res.row expected %h got %h", exp_head.row, $sampled(o_res.row));
        end
    assert property (@(posedge clk) disable iff (rst)
        o_res_valid && exp_avail |-> o_res.col == exp_head.col)
        else begin
            errors++;
            $display("Error: o_res.col expected %h got %h", exp_head.col, $sampled(o_res.col));
        end
    assert property (@(posedge clk) disable iff (rst)
        o_res_valid && exp_avail |-> o_res.last == exp_head.last)
        else begin
            errors++;
            $display("Error: o_res.last expected %h got %h", exp_head.last, $sampled(o_res.last));
        end
    assert property (@(posedge clk) disable iff (rst) unacked <= MAX_CREDITS)
        else begin
            errors++;
            $display("more results outstanding than the engine has credits");
        end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $finish;
    endtask

    // zero-padded 5x5 correlation of one stored frame in raster order
    task automatic model_frame(input int f);
        int   acc;
        int   rr;
        int   cc;
        res_t e;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                acc = 0;
                for (int kr = 0; kr < KSIZE; kr++) begin
                    for (int kc = 0; kc < KSIZE; kc++) begin
                        rr = r + kr - HALF;
                        cc = c + kc - HALF;
                        if (rr >= 0 && rr < ROWS && cc >= 0 && cc < COLS) begin
                            acc += img[f][rr*COLS+cc] * kern[kr*KSIZE+kc];
                        end
                    end
                end
                e.data = RES_W'(acc);
                e.row  = POS_W'(r);
                e.col  = POS_W'(c);
                e.last = (r == ROWS - 1) && (c == COLS - 1);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic load_kernel();
        for (int k = 0; k < KSIZE * KSIZE; k++) begin
            i_coef_we   = 1'b1;
            i_coef_addr = 5'(k);
            i_coef_data = COEF_W'(kern[k]);
            @(negedge clk);
        end
        i_coef_we = 1'b0;
    endtask

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic push_pixel(input int p);
        int waited;
        waited      = 0;
        i_pix       = PIX_W'(p);
        i_pix_valid = 1'b1;
        while (!o_pix_ready) begin
            @(negedge clk);
            waited++;
            if (waited > PIX_LIMIT) abort_run("timeout: o_pix_ready stayed low");
        end
        @(negedge clk);
        i_pix_valid = 1'b0;
    endtask

    task automatic send_frame(input int f, input int gap_odds);
        for (int i = 0; i < NPIX; i++) begin
            if (gap_odds > 0 && ($urandom % gap_odds) == 0) begin
                repeat (1 + $urandom % 3) @(negedge clk);
            end
            push_pixel(img[f][i]);
        end
    endtask

    task automatic wait_results(input int target);
        int cycles;
        cycles = 0;
        while (got < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > DRAIN_LIMIT) abort_run("timeout: the first results never arrived");
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || unacked != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > DRAIN_LIMIT) abort_run("timeout: the frame did not complete");
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic fill_random(input int f);
        for (int i = 0; i < NPIX; i++) begin
            img[f][i] = int'($urandom % 256);
        end
    endtask

    task automatic report(input int n, input string name);
        $display("[%0d] %s: %0d results, %0d errors so far", n, name, got - base, errors);
        base = got;
    endtask

    initial begin
        void'($urandom(52));
        rst          = 1'b1;
        i_pix_valid  = 1'b0;
        i_pix        = '0;
        i_coef_we    = 1'b0;
        i_coef_addr  = '0;
        i_coef_data  = '0;
        i_res_credit = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // reset state and then a zero-kernel frame with credits withheld
        assert (o_res_valid == 1'b0)
            else begin
                errors++;
                $display("Error: o_res_valid expected 0 got %h", o_res_valid);
            end
        assert (o_pix_ready == 1'b1)
            else begin
                errors++;
                $display("Error: o_pix_ready expected 1 got %h", o_pix_ready);
            end
        foreach (kern[k]) kern[k] = 0;
        fill_random(0);
        model_frame(0);
        hold_credits = 1'b1;
        fork
            send_frame(0, 0);
            begin
                wait_results(MAX_CREDITS);
                repeat (40) @(negedge clk);
                assert (got == MAX_CREDITS)
                    else begin
                        errors++;
                        $display("results kept coming with no credit returned");
                    end
                hold_credits = 1'b0;
            end
        join
        wait_drained();
        report(1, "reset state");

        // only the centre tap set
        kern[(KSIZE*KSIZE)/2] = 1;
        load_kernel();
        for (int i = 0; i < NPIX; i++) begin
            img[0][i] = (i * 5 + 3) % 256;
        end
        model_frame(0);
        send_frame(0, 0);
        wait_drained();
        report(2, "identity kernel");

        foreach (kern[k]) kern[k] = 1;
        load_kernel();
        for (int i = 0; i < NPIX; i++) begin
            img[0][i] = 1;
        end
        model_frame(0);
        send_frame(0, 0);
        wait_drained();
        report(3, "edge padding");

        foreach (kern[k]) kern[k] = int'($urandom % 256) - 128;
        load_kernel();
        fill_random(0);
        model_frame(0);
        send_frame(0, 0);
        wait_drained();
        report(4, "random kernel");

        // long credit stalls with short release windows
        fill_random(0);
        model_frame(0);
        fork
            send_frame(0, 0);
            for (int k = 0; k < 10; k++) begin
                hold_credits = 1'b1;
                repeat (20 + $urandom % 40) @(negedge clk);
                hold_credits = 1'b0;
                repeat (3 + $urandom % 8) @(negedge clk);
            end
        join
        wait_drained();
        report(5, "credit back-pressure");

        fill_random(0);
        fill_random(1);
        model_frame(0);
        model_frame(1);
        send_frame(0, 3);
        send_frame(1, 3);
        wait_drained();
        report(6, "back-to-back frames");

        $display("summary: 6 tests, %0d results checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* conv_engine_top.f */
src/conv_pkg.sv
src/conv_frame_ctrl.sv
src/conv_line_buffer.sv
src/conv_window_5x5.sv
src/conv_mac_5x5.sv
src/conv_engine_top.sv
sim/conv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module conv_tb -f conv_engine_top.f

output=$(./obj_dir/Vconv_tb)
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
